/* src/mesm6_alu_pkg.sv */
package mesm6_alu_pkg;

    // Data path width of the unit.
    localparam int WORD_WIDTH = 48;

    // The exponent field of b doubles as the shift code.
    localparam int SHIFT_CODE_LSB = 41;
    localparam int SHIFT_ZERO     = 64;
    localparam int SHIFT_STEP     = 4;

    typedef logic [WORD_WIDTH-1:0]             word_t;
    typedef logic [WORD_WIDTH-1:SHIFT_CODE_LSB] shift_code_t;
    typedef logic [5:0]                        bit_count_t;

    // Operation code, held steady by the caller until done.
    typedef enum logic [3:0] {
        OP_NOP,
        OP_YTA,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ARX,
        OP_ACX,
        OP_ANX,
        OP_SHIFT,
        OP_PACK,
        OP_UNPACK
    } alu_op_t;

    // First step of the count and add unit.
    typedef enum logic [1:0] {
        ARX,
        ACX,
        ANX
    } count_mode_t;

endpackage

/* src/alu_unit_if.sv */
interface alu_unit_if
    import mesm6_alu_pkg::*;
();

    // Start pulse and operands, valid together for one cycle.
    logic  start;
    word_t a;
    word_t b;

    // Unit outputs, valid in the cycle done is high.
    word_t result;
    word_t y_res;
    logic  done;

    modport seq (
        output start,
        output a,
        output b,
        input  result,
        input  y_res,
        input  done
    );

    modport unit (
        input  start,
        input  a,
        input  b,
        output result,
        output y_res,
        output done
    );

endinterface

/* src/alu_sequencer.sv */
module alu_sequencer
    import mesm6_alu_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  alu_op_t        op,
    input  logic           wy,
    input  word_t          a,
    input  word_t          b,
    output word_t          acc,
    output word_t          y,
    output logic           done,
    output count_mode_t    count_mode,
    alu_unit_if.seq        cnt_bus,
    alu_unit_if.seq        shf_bus,
    alu_unit_if.seq        bit_bus,
    output logic           bitfield_unpack
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_FINISHED
    } state_t;

    state_t state;
    logic   is_count;
    logic   is_shift;
    logic   is_field;
    logic   unit_done;
    word_t  unit_result;
    word_t  unit_y;

    assign is_count = op inside {OP_ARX, OP_ACX, OP_ANX};
    assign is_shift = (op == OP_SHIFT);
    assign is_field = op inside {OP_PACK, OP_UNPACK};

    // Start only from idle, so each unit sees a single pulse.
    assign cnt_bus.start = (state == S_IDLE) && is_count;
    assign shf_bus.start = (state == S_IDLE) && is_shift;
    assign bit_bus.start = (state == S_IDLE) && is_field;

    assign cnt_bus.a = a;
    assign cnt_bus.b = b;
    assign shf_bus.a = a;
    assign shf_bus.b = b;
    assign bit_bus.a = a;
    assign bit_bus.b = b;

    assign bitfield_unpack = (op == OP_UNPACK);

    always_comb begin
        case (op)
            OP_ACX:  count_mode = ACX;
            OP_ANX:  count_mode = ANX;
            default: count_mode = ARX;
        endcase
    end

    // Pick the bus of the unit that is working on the current op.
    always_comb begin
        if (is_count) begin
            unit_done   = cnt_bus.done;
            unit_result = cnt_bus.result;
            unit_y      = cnt_bus.y_res;
        end else if (is_shift) begin
            unit_done   = shf_bus.done;
            unit_result = shf_bus.result;
            unit_y      = shf_bus.y_res;
        end else begin
            unit_done   = bit_bus.done;
            unit_result = bit_bus.result;
            unit_y      = bit_bus.y_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            acc   <= '0;
            y     <= '0;
            done  <= 1'b0;
        end else if (op == OP_NOP) begin
            // Back to idle; Y may be written from a.
            state <= S_IDLE;
            done  <= 1'b0;
            if (wy) begin
                y <= a;
            end
        end else begin
            case (state)
                S_IDLE: begin
                    case (op)
                        OP_YTA: begin
                            acc   <= y;
                            done  <= 1'b1;
                            state <= S_FINISHED;
                        end
                        OP_AND: begin
                            acc   <= a & b;
                            y     <= '0;
                            done  <= 1'b1;
                            state <= S_FINISHED;
                        end
                        OP_OR: begin
                            acc   <= a | b;
                            y     <= '0;
                            done  <= 1'b1;
                            state <= S_FINISHED;
                        end
                        OP_XOR: begin
                            acc   <= a ^ b;
                            y     <= a;
                            done  <= 1'b1;
                            state <= S_FINISHED;
                        end
                        default: begin
                            if (is_count || is_shift || is_field) begin
                                state <= S_WAIT;
                            end
                        end
                    endcase
                end
                S_WAIT: begin
                    if (unit_done) begin
                        acc   <= unit_result;
                        y     <= unit_y;
                        done  <= 1'b1;
                        state <= S_FINISHED;
                    end
                end
                default: begin
                    // Result held until op returns to NOP.
                end
            endcase
        end
    end

endmodule

/* src/alu_count_add.sv */
module alu_count_add
    import mesm6_alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  count_mode_t mode,
    alu_unit_if.unit    bus
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADD_B,
        S_ADD_CARRY
    } state_t;

    state_t              state;
    logic [WORD_WIDTH:0] sum_q;
    word_t               b_q;
    word_t               y_q;
    bit_count_t          ones;
    bit_count_t          lzc;

    function automatic bit_count_t count_ones(word_t w);
        bit_count_t n;
        n = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            n = n + bit_count_t'(w[i]);
        end
        return n;
    endfunction

    // Full width when the word is zero.
    function automatic bit_count_t count_lz(word_t w);
        bit_count_t n;
        n = bit_count_t'(WORD_WIDTH);
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (w[i]) begin
                n = bit_count_t'(WORD_WIDTH - 1 - i);
            end
        end
        return n;
    endfunction

    assign ones = count_ones(bus.a);
    assign lzc  = count_lz(bus.a);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bus.start) begin
                        state <= (mode == ARX) ? S_ADD_CARRY : S_ADD_B;
                    end
                end
                S_ADD_B:     state <= S_ADD_CARRY;
                default:     state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && bus.start) begin
            b_q <= bus.b;
            case (mode)
                ACX: begin
                    sum_q <= {1'b0, word_t'(ones)};
                    y_q   <= '0;
                end
                ANX: begin
                    // Count plus one, and zero for a zero word.
                    sum_q <= (bus.a == '0) ? '0 : {1'b0, word_t'(lzc + 1'b1)};
                    y_q   <= bus.a << lzc;
                end
                default: begin
                    sum_q <= {1'b0, bus.a} + {1'b0, bus.b};
                    y_q   <= '0;
                end
            endcase
        end else if (state == S_ADD_B) begin
            sum_q <= {1'b0, sum_q[WORD_WIDTH-1:0]} + {1'b0, b_q};
        end
    end

    // End-around carry goes back into the low bit.
    assign bus.result = sum_q[WORD_WIDTH-1:0] + word_t'(sum_q[WORD_WIDTH]);
    assign bus.y_res  = y_q;
    assign bus.done   = (state == S_ADD_CARRY);

endmodule

/* src/alu_shifter.sv */
module alu_shifter
    import mesm6_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    alu_unit_if.unit bus
);

    typedef enum logic {
        S_IDLE,
        S_SHIFT
    } state_t;

    state_t      state;
    word_t       hi;
    word_t       lo;
    shift_code_t code;
    logic        at_zero;
    logic        go_right;
    logic [2:0]  step;

    assign at_zero  = (code == shift_code_t'(SHIFT_ZERO));
    assign go_right = (code > shift_code_t'(SHIFT_ZERO));

    // The odd remainder is taken first, then whole steps of four.
    always_comb begin
        if (code[SHIFT_CODE_LSB+1:SHIFT_CODE_LSB] == 2'd0) begin
            step = 3'(SHIFT_STEP);
        end else if (go_right) begin
            step = {1'b0, code[SHIFT_CODE_LSB+1:SHIFT_CODE_LSB]};
        end else begin
            step = 3'(SHIFT_STEP) - {1'b0, code[SHIFT_CODE_LSB+1:SHIFT_CODE_LSB]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (state == S_IDLE) begin
            if (bus.start) begin
                state <= S_SHIFT;
            end
        end else if (at_zero) begin
            state <= S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            if (bus.start) begin
                hi   <= bus.a;
                lo   <= '0;
                code <= bus.b[WORD_WIDTH-1:SHIFT_CODE_LSB];
            end
        end else if (!at_zero) begin
            if (go_right) begin
                // Acc bits fall into Y.
                {hi, lo} <= {hi, lo} >> step;
                code     <= code - shift_code_t'(step);
            end else begin
                {lo, hi} <= {lo, hi} << step;
                code     <= code + shift_code_t'(step);
            end
        end
    end

    assign bus.done   = (state == S_SHIFT) && at_zero;
    assign bus.result = hi;
    assign bus.y_res  = lo;

endmodule

/* src/alu_bitfield.sv */
module alu_bitfield
    import mesm6_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     unpack,
    alu_unit_if.unit bus
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PACK,
        S_UNPACK
    } state_t;

    state_t     state;
    word_t      acc_q;
    word_t      src_q;
    word_t      mask_q;
    bit_count_t steps;
    logic       finish;

    // Pack ends with an empty mask, unpack after a full word of steps.
    assign finish = ((state == S_PACK) && (mask_q == '0)) ||
                    ((state == S_UNPACK) && (steps == '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (state == S_IDLE) begin
            if (bus.start) begin
                state <= unpack ? S_UNPACK : S_PACK;
            end
        end else if (finish) begin
            state <= S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            if (bus.start) begin
                acc_q  <= '0;
                src_q  <= bus.a;
                mask_q <= bus.b;
                steps  <= bit_count_t'(WORD_WIDTH);
            end
        end else if (!finish) begin
            if (state == S_PACK) begin
                // Gather under set mask bits, low bit first.
                if (mask_q[0]) begin
                    acc_q <= {src_q[0], acc_q[WORD_WIDTH-1:1]};
                end
                mask_q <= mask_q >> 1;
                src_q  <= src_q >> 1;
            end else begin
                // Scatter from the top; source moves only on set bits.
                acc_q  <= {acc_q[WORD_WIDTH-2:0], src_q[WORD_WIDTH-1] & mask_q[WORD_WIDTH-1]};
                mask_q <= mask_q << 1;
                steps  <= steps - 1'b1;
                if (mask_q[WORD_WIDTH-1]) begin
                    src_q <= src_q << 1;
                end
            end
        end
    end

    assign bus.done   = finish;
    assign bus.result = acc_q;
    assign bus.y_res  = '0;

endmodule

/* src/mesm6_alu.sv */
module mesm6_alu
    import mesm6_alu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  alu_op_t op,
    input  logic    wy,
    input  word_t   a,
    input  word_t   b,
    output word_t   acc,
    output word_t   y,
    output logic    done
);

    count_mode_t count_mode;
    logic        bitfield_unpack;

    // One bus per multicycle unit.
    alu_unit_if cnt_bus ();
    alu_unit_if shf_bus ();
    alu_unit_if bit_bus ();

    alu_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .op              (op),
        .wy              (wy),
        .a               (a),
        .b               (b),
        .acc             (acc),
        .y               (y),
        .done            (done),
        .count_mode      (count_mode),
        .cnt_bus         (cnt_bus),
        .shf_bus         (shf_bus),
        .bit_bus         (bit_bus),
        .bitfield_unpack (bitfield_unpack)
    );

    alu_count_add u_count_add (
        .clk   (clk),
        .rst_n (rst_n),
        .mode  (count_mode),
        .bus   (cnt_bus)
    );

    alu_shifter u_shifter (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (shf_bus)
    );

    alu_bitfield u_bitfield (
        .clk    (clk),
        .rst_n  (rst_n),
        .unpack (bitfield_unpack),
        .bus    (bit_bus)
    );

endmodule

/* sim/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// One xorshift32 step for repeatable stimulus.
function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Sum with the carry out folded back into bit 0.
function automatic word_t eac_add(word_t x, word_t z);
    logic [WORD_WIDTH:0] s;
    s = x + z;
    return s[WORD_WIDTH-1:0] + word_t'(s[WORD_WIDTH]);
endfunction

function automatic int pop_count(word_t w);
    int n;
    n = 0;
    for (int i = 0; i < WORD_WIDTH; i++) begin
        n += int'(w[i]);
    end
    return n;
endfunction

// Zeros above the highest one, 48 for a zero word.
function automatic int lead_zeros(word_t w);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
        seen = seen | w[i];
        if (!seen)
            n++;
    end
    return n;
endfunction

// Acc and Y after ARX, ACX or ANX, packed as {acc, y}.
function automatic logic [2*WORD_WIDTH-1:0] count_model(alu_op_t o, word_t x, word_t z);
    int lz;
    lz = lead_zeros(x);
    case (o)
        OP_ACX:  return {eac_add(word_t'(pop_count(x)), z), word_t'(0)};
        OP_ANX:  return {eac_add((x == '0) ? word_t'(0) : word_t'(lz + 1), z), x << lz};
        default: return {eac_add(x, z), word_t'(0)};
    endcase
endfunction

// Shift of a through the acc and Y pair, packed as {acc, y}.
function automatic logic [2*WORD_WIDTH-1:0] shift_model(word_t x, int code);
    logic [2*WORD_WIDTH-1:0] p;
    if (code >= SHIFT_ZERO) begin
        p = {x, word_t'(0)} >> (code - SHIFT_ZERO);
        return p;
    end else begin
        // Left shift runs over Y above acc.
        p = {word_t'(0), x} << (SHIFT_ZERO - code);
        return {p[WORD_WIDTH-1:0], p[2*WORD_WIDTH-1:WORD_WIDTH]};
    end
endfunction

// Source bits under the mask fill the top of the word, lowest mask bit lowest.
function automatic word_t gather_bits(word_t src, word_t mask);
    word_t r;
    int    j;
    r = '0;
    j = WORD_WIDTH - pop_count(mask);
    for (int i = 0; i < WORD_WIDTH; i++) begin
        if (mask[i]) begin
            r[j] = src[i];
            j++;
        end
    end
    return r;
endfunction

// Source bits from the MSB down land on the set mask bits, top first.
function automatic word_t scatter_bits(word_t src, word_t mask);
    word_t r;
    int    j;
    r = '0;
    j = WORD_WIDTH - 1;
    for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
        if (mask[i]) begin
            r[i] = src[j];
            j--;
        end
    end
    return r;
endfunction

`endif

/* sim/tb_mesm6_alu.sv */
module tb_mesm6_alu
    import mesm6_alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // About 55 operations, the longest near 60 cycles, with margin.
    localparam int MAX_CYCLES = 4000;

    localparam word_t EDGE_A [4] = '{48'h0, 48'hffff_ffff_ffff, 48'h8000_0000_0000, 48'h1};
    localparam word_t EDGE_B [4] = '{48'h0, 48'h1, 48'hffff_ffff_ffff, 48'h8000_0000_0000};
    localparam alu_op_t COUNT_OPS [3] = '{OP_ARX, OP_ACX, OP_ANX};
    localparam int SHIFT_CODES [12] = '{64, 63, 62, 61, 60, 65, 66, 67, 45, 90, 0, 127};
    localparam word_t MASKS [5] = '{48'hffff_ffff_ffff, 48'h1, 48'h0000_0400_0000,
                                    48'h8000_0000_0000, 48'h0};

    logic    clk;
    logic    rst_n;
    logic    wy;
    logic    done;
    alu_op_t op;
    word_t   a;
    word_t   b;
    word_t   acc;
    word_t   y;

    word_t       exp_acc;
    word_t       exp_y;
    word_t       y_model;
    int          exp_lat;
    int          edges;
    int          cycles = 0;
    int          errors = 0;
    int          test_errors;
    int          tests = 0;
    int          failed_tests = 0;
    int          ops = 0;
    string       test_name;
    logic [31:0] rng = 32'hf016_aeab;

    `include "alu_ref_model.svh"

    mesm6_alu dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Edges sampled with a non-NOP op, so done latency can be read off.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            edges <= 0;
        else if (op == OP_NOP)
            edges <= 0;
        else
            edges <= edges + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    acc_value: assert property (@(posedge clk) disable iff (!rst_n) done |-> acc == exp_acc)
        else begin
            $display("ERROR acc: got %h expected %h", $sampled(acc), $sampled(exp_acc));
            errors++;
        end

    y_value: assert property (@(posedge clk) disable iff (!rst_n) done |-> y == exp_y)
        else begin
            $display("ERROR y: got %h expected %h", $sampled(y), $sampled(exp_y));
            errors++;
        end

    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(done) && exp_lat != 0) |-> edges == exp_lat)
        else begin
            $display("ERROR done edge: got %0h expected %0h", $sampled(edges), $sampled(exp_lat));
            errors++;
        end

    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        (done && op != OP_NOP) |=> (done && $stable(acc) && $stable(y)))
        else begin
            $display("done, acc or y changed while the op was still held");
            errors++;
        end

    done_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (op == OP_NOP) |=> !done)
        else begin
            $display("done stayed high after op returned to NOP");
            errors++;
        end

    function automatic word_t random_word();
        word_t w;
        rng = xorshift32(rng);
        w[47:32] = rng[15:0];
        rng = xorshift32(rng);
        w[31:0] = rng;
        return w;
    endfunction

    task automatic check_word(string name, word_t got, word_t want);
        assert (got == want)
            else begin
                $display("ERROR %s: got %h expected %h", name, got, want);
                errors++;
            end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        // One more edge so the checks of the last op are counted here.
        @(posedge clk);
        #1;
        tests++;
        if (errors != test_errors)
            failed_tests++;
        $display("%-6s %s, %0d errors", test_name, (errors == test_errors) ? "ok" : "fail",
                 errors - test_errors);
    endtask

    task automatic load_y(word_t x);
        a = x;
        wy = 1'b1;
        @(posedge clk);
        #1;
        wy = 1'b0;
        check_word("y", y, x);
        y_model = x;
    endtask

    // Holds op until done, then for hold more edges, then returns to NOP.
    task automatic run_op(alu_op_t o, word_t x, word_t z, word_t want_acc, word_t want_y,
                          int lat, int hold);
        exp_acc = want_acc;
        exp_y = want_y;
        exp_lat = lat;
        op = o;
        a = x;
        b = z;
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        op = OP_NOP;
        @(posedge clk);
        #1;
        y_model = want_y;
        ops++;
    endtask

    task automatic run_count(alu_op_t o, word_t x, word_t z, int hold);
        logic [2*WORD_WIDTH-1:0] r;
        r = count_model(o, x, z);
        run_op(o, x, z, r[2*WORD_WIDTH-1:WORD_WIDTH], r[WORD_WIDTH-1:0],
               (o == OP_ARX) ? 2 : 3, hold);
    endtask

    task automatic run_shift(int code, word_t x);
        logic [2*WORD_WIDTH-1:0] r;
        word_t                   z;
        z = random_word();
        z[WORD_WIDTH-1:SHIFT_CODE_LSB] = shift_code_t'(code);
        r = shift_model(x, code);
        run_op(OP_SHIFT, x, z, r[2*WORD_WIDTH-1:WORD_WIDTH], r[WORD_WIDTH-1:0], 0, 1);
    endtask

    task automatic run_field(word_t x, word_t mask);
        int lat;
        lat = (mask == '0) ? 2 : (WORD_WIDTH - 1 - lead_zeros(mask)) + 3;
        run_op(OP_PACK, x, mask, gather_bits(x, mask), '0, lat, 1);
        run_op(OP_UNPACK, x, mask, scatter_bits(x, mask), '0, 50, 1);
    endtask

    initial begin
        word_t x;
        word_t z;
        op = OP_NOP;
        wy = 1'b0;
        a = '0;
        b = '0;
        exp_acc = '0;
        exp_y = '0;
        exp_lat = 0;
        y_model = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset");
        check_word("done", word_t'(done), '0);
        check_word("acc", acc, '0);
        check_word("y", y, '0);
        finish_test();

        start_test("logic");
        load_y(random_word());
        run_op(OP_YTA, random_word(), random_word(), y_model, y_model, 1, 1);
        repeat (2) begin
            x = random_word();
            z = random_word();
            run_op(OP_AND, x, z, x & z, '0, 1, 1);
            run_op(OP_OR, x, z, x | z, '0, 1, 1);
            run_op(OP_XOR, x, z, x ^ z, x, 1, 1);
        end
        run_op(OP_YTA, random_word(), random_word(), y_model, y_model, 1, 1);
        finish_test();

        start_test("count");
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 6; i++) begin
                x = (i < 4) ? EDGE_A[i] : random_word();
                z = (i < 4) ? EDGE_B[i] : random_word();
                run_count(COUNT_OPS[k], x, z, 1);
            end
        end
        finish_test();

        start_test("shift");
        for (int i = 0; i < 12; i++) begin
            run_shift(SHIFT_CODES[i], random_word());
        end
        finish_test();

        start_test("field");
        for (int i = 0; i < 5; i++) begin
            run_field(random_word(), MASKS[i]);
        end
        run_field(random_word(), random_word());
        run_field(random_word(), random_word());
        finish_test();

        // Results must stay put while op is held long after done.
        start_test("hold");
        x = random_word();
        z = random_word();
        run_op(OP_XOR, x, z, x ^ z, x, 1, 8);
        run_count(OP_ANX, random_word(), random_word(), 8);
        finish_test();

        $display("%0d tests, %0d failed, %0d ops, %0d errors", tests, failed_tests, ops, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+sim
src/mesm6_alu_pkg.sv
src/alu_unit_if.sv
src/alu_sequencer.sv
src/alu_count_add.sv
src/alu_shifter.sv
src/alu_bitfield.sv
src/mesm6_alu.sv
sim/tb_mesm6_alu.sv

/* Bender.yml */
package:
  name: mesm6_alu

sources:
  - files:
      - src/mesm6_alu_pkg.sv
      - src/alu_unit_if.sv
      - src/alu_sequencer.sv
      - src/alu_count_add.sv
      - src/alu_shifter.sv
      - src/alu_bitfield.sv
      - src/mesm6_alu.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mesm6_alu.sv
